// File: src/mmul_pkg.sv
package mmul_pkg;

    localparam int DIM    = 8;   // Matrix dimension
    localparam int BYTE_W = 8;
    localparam int ACC_W  = 24;  // Dot product width
    localparam int ROW_W  = 64;  // One memory row holds DIM bytes
    localparam int ADDR_W = 32;

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [ROW_W-1:0]  row_t;   // Byte 0 in the top eight bits
    typedef logic [ACC_W-1:0]  acc_t;
    typedef logic [2:0]        idx_t;   // Row, column or result index
    typedef logic [6:0]        seg_t;   // Active low segments

    typedef enum logic [2:0] {
        IDLE,
        READ,
        FILL_B,
        FILL_A,
        EXEC,
        DONE
    } state_t;

    // Hex digit patterns 0 to F
    localparam seg_t SEG_HEX [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0011000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

    localparam seg_t SEG_OFF = 7'b1111111;

endpackage

// File: src/buf_if.sv
`timescale 1ns/1ns

interface buf_if;
    import mmul_pkg::*;

    logic  wr_b;     // Write B at the current column
    logic  wr_a;     // Push into the current row's queue
    logic  rd_a;     // Pop the current row's queue
    byte_t wr_byte;  // Row byte picked by column
    byte_t a_out;    // Head of the current row's queue
    byte_t b_out;    // B at the current column
    logic  a_empty;

    // Controller side
    modport ctrl (
        output wr_b,
        output wr_a,
        output rd_a,
        input  a_empty
    );

    modport buffers (
        input  wr_b,
        input  wr_a,
        input  rd_a,
        output wr_byte,
        output a_out,
        output b_out,
        output a_empty
    );

endinterface

// File: src/mmul_ctrl.sv
`timescale 1ns/1ns

module mmul_ctrl (
    input  logic           CLOCK_50,
    input  logic           rst_n,
    output logic           read,
    input  logic           readdatavalid,
    input  logic           waitrequest,
    buf_if.ctrl            ctrl,
    output logic           col_step,
    output logic           row_step,
    input  logic           col_last,
    input  logic           row_last,
    input  mmul_pkg::idx_t load_row,
    output logic           capture,
    output logic           mac_en,
    output logic           mac_clr,
    output logic           done
);
    import mmul_pkg::*;

    state_t     state;
    state_t     next_state;
    logic       req_taken;  // Memory has accepted the pending read
    logic [1:0] tail;       // Last pop of a row moving through the MAC pipe
    logic       pop;
    logic       b_read;
    logic       row_back;

    // Address 0 is the only load with index 0 before the last row
    assign b_read = (load_row == '0) && !row_last;

    // Row has returned, accepted earlier or in this very cycle
    assign row_back = readdatavalid && (req_taken || !waitrequest);

    assign read = (state == READ);
    assign done = (state == DONE);

    // Pops pause while the previous row drains out of the MAC
    assign pop = (state == EXEC) && (tail == '0);

    assign ctrl.wr_b = (state == FILL_B);
    assign ctrl.wr_a = (state == FILL_A);
    assign ctrl.rd_a = pop;

    assign col_step = (state == FILL_B) || (state == FILL_A) || pop;
    assign row_step = ((state == FILL_A) && col_last) || capture;

    assign mac_en  = pop;
    assign capture = tail[1];   // Eighth product is in the accumulator
    assign mac_clr = tail[1];

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            req_taken <= 1'b0;
            tail      <= '0;
        end else begin
            state <= next_state;
            tail  <= {tail[0], pop && col_last};
            if ((state != READ) || readdatavalid)
                req_taken <= 1'b0;
            else if (!waitrequest)
                req_taken <= 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    next_state = READ;
            READ: begin
                if (row_back)
                    next_state = b_read ? FILL_B : FILL_A;
            end
            FILL_B: begin
                if (col_last)
                    next_state = READ;
            end
            FILL_A: begin
                if (col_last)
                    next_state = row_last ? EXEC : READ;  // All rows loaded
            end
            EXEC: begin
                if (capture && ctrl.a_empty)
                    next_state = DONE;
            end
            DONE:    next_state = DONE;  // Held until reset
            default: next_state = IDLE;
        endcase
    end

endmodule

// File: src/mmul_counters.sv
`timescale 1ns/1ns

module mmul_counters #(
    parameter int DIM = mmul_pkg::DIM
) (
    input  logic                        CLOCK_50,
    input  logic                        rst_n,
    input  logic                        col_step,
    input  logic                        row_step,
    output mmul_pkg::idx_t              col,
    output mmul_pkg::idx_t              row,
    output mmul_pkg::idx_t              load_row,
    output logic [mmul_pkg::ADDR_W-1:0] address,
    output logic                        col_last,
    output logic                        row_last
);
    import mmul_pkg::*;

    localparam idx_t LAST = idx_t'(DIM - 1);

    assign col_last = (col == LAST);
    assign row_last = (row == LAST);

    // Number of the row being loaded, 0 being the vector
    assign load_row = idx_t'(address);

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n)
            col <= '0;
        else if (col_step)
            col <= col_last ? '0 : col + 1'b1;
    end

    // Shared by loading and execution
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n)
            row <= '0;
        else if (row_step)
            row <= row_last ? '0 : row + 1'b1;
    end

    // Next memory row after each fill, stops once A is in
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n)
            address <= '0;
        else if (col_step && col_last && (address != ADDR_W'(DIM)))
            address <= address + 1'b1;
    end

endmodule

// File: src/operand_buffers.sv
`timescale 1ns/1ns

module operand_buffers #(
    parameter int DIM = mmul_pkg::DIM
) (
    input  logic           CLOCK_50,
    input  logic           rst_n,
    input  logic           readdatavalid,
    input  mmul_pkg::row_t readdata,
    input  mmul_pkg::idx_t col,
    input  mmul_pkg::idx_t row,
    buf_if.buffers         bufs
);
    import mmul_pkg::*;

    localparam int PW = $clog2(DIM);

    row_t           row_q;       // Last row returned by memory
    byte_t          b_mem [DIM];
    byte_t          head [DIM];
    logic [DIM-1:0] empty;

    always_ff @(posedge CLOCK_50) begin
        if (readdatavalid)
            row_q <= readdata;
    end

    // Byte 0 sits at the top of the row
    assign bufs.wr_byte = row_q[ROW_W - 1 - BYTE_W * col -: BYTE_W];

    always_ff @(posedge CLOCK_50) begin
        if (bufs.wr_b)
            b_mem[col[PW-1:0]] <= bufs.wr_byte;
    end

    assign bufs.b_out   = b_mem[col[PW-1:0]];
    assign bufs.a_out   = head[row[PW-1:0]];
    assign bufs.a_empty = &empty;

    // One queue per row of A
    for (genvar q = 0; q < DIM; q++) begin : g_queue
        byte_t       mem [DIM];
        logic [PW:0] wr_ptr;     // Extra bit tells full from empty
        logic [PW:0] rd_ptr;
        logic        this_row;

        assign this_row = (row == idx_t'(q));
        assign empty[q] = (wr_ptr == rd_ptr);
        assign head[q]  = mem[rd_ptr[PW-1:0]];

        always_ff @(posedge CLOCK_50) begin
            if (bufs.wr_a && this_row)
                mem[wr_ptr[PW-1:0]] <= bufs.wr_byte;
        end

        always_ff @(posedge CLOCK_50 or negedge rst_n) begin
            if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (bufs.wr_a && this_row)
                    wr_ptr <= wr_ptr + 1'b1;
                if (bufs.rd_a && this_row && !empty[q])
                    rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: src/mac_unit.sv
`timescale 1ns/1ns

module mac_unit (
    input  logic            CLOCK_50,
    input  logic            rst_n,
    input  logic            en,
    input  logic            clr,
    input  mmul_pkg::byte_t a,
    input  mmul_pkg::byte_t b,
    output mmul_pkg::acc_t  acc
);
    import mmul_pkg::*;

    byte_t               a_r;
    byte_t               b_r;
    logic                en_r;   // Operand registers hold a live pair
    logic [2*BYTE_W-1:0] prod;

    assign prod = a_r * b_r;

    // Operand stage
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            a_r  <= '0;
            b_r  <= '0;
            en_r <= 1'b0;
        end else if (clr) begin
            a_r  <= '0;
            b_r  <= '0;
            en_r <= 1'b0;
        end else begin
            en_r <= en;
            if (en) begin
                a_r <= a;
                b_r <= b;
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n)
            acc <= '0;
        else if (clr)
            acc <= '0;
        else if (en_r)
            acc <= acc + ACC_W'(prod);
    end

endmodule

// File: src/result_display.sv
`timescale 1ns/1ns

module result_display (
    input  logic           CLOCK_50,
    input  logic           rst_n,
    input  logic           capture,
    input  mmul_pkg::acc_t acc,
    input  mmul_pkg::idx_t row,
    input  logic           done,
    input  logic           show,
    input  mmul_pkg::idx_t sel,
    output mmul_pkg::seg_t hex0,
    output mmul_pkg::seg_t hex1,
    output mmul_pkg::seg_t hex2,
    output mmul_pkg::seg_t hex3,
    output mmul_pkg::seg_t hex4,
    output mmul_pkg::seg_t hex5
);
    import mmul_pkg::*;

    acc_t           bank [DIM];
    acc_t           shown;
    logic           lit;
    seg_t           digit [6];

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n)
            bank <= '{default: '0};
        else if (capture)
            bank[row] <= acc;
    end

    assign shown = bank[sel];
    assign lit   = done && show;

    // One digit per nibble with the least significant on hex0
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            digit[i] = lit ? SEG_HEX[shown[4*i +: 4]] : SEG_OFF;
        end
    end

    assign hex0 = digit[0];
    assign hex1 = digit[1];
    assign hex2 = digit[2];
    assign hex3 = digit[3];
    assign hex4 = digit[4];
    assign hex5 = digit[5];

endmodule

// File: src/mmul_top.sv
`timescale 1ns/1ns

module mmul_top #(
    parameter int DIM = mmul_pkg::DIM
) (
    input  logic                        CLOCK_50,
    input  logic                        rst_n,
    output logic [mmul_pkg::ADDR_W-1:0] address,
    output logic                        read,
    input  mmul_pkg::row_t              readdata,
    input  logic                        readdatavalid,
    input  logic                        waitrequest,
    input  logic                        show,
    input  mmul_pkg::idx_t              sel,
    output logic                        done,
    output mmul_pkg::seg_t              hex0,
    output mmul_pkg::seg_t              hex1,
    output mmul_pkg::seg_t              hex2,
    output mmul_pkg::seg_t              hex3,
    output mmul_pkg::seg_t              hex4,
    output mmul_pkg::seg_t              hex5
);
    import mmul_pkg::*;

    idx_t col;
    idx_t row;
    idx_t load_row;
    logic col_step;
    logic row_step;
    logic col_last;
    logic row_last;
    logic capture;
    logic mac_en;
    logic mac_clr;
    acc_t acc;

    buf_if u_buf ();

    mmul_ctrl i_ctrl (
        .CLOCK_50      (CLOCK_50),
        .rst_n         (rst_n),
        .read          (read),
        .readdatavalid (readdatavalid),
        .waitrequest   (waitrequest),
        .ctrl          (u_buf.ctrl),
        .col_step      (col_step),
        .row_step      (row_step),
        .col_last      (col_last),
        .row_last      (row_last),
        .load_row      (load_row),
        .capture       (capture),
        .mac_en        (mac_en),
        .mac_clr       (mac_clr),
        .done          (done)
    );

    mmul_counters #(
        .DIM (DIM)
    ) i_counters (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .col_step (col_step),
        .row_step (row_step),
        .col      (col),
        .row      (row),
        .load_row (load_row),
        .address  (address),
        .col_last (col_last),
        .row_last (row_last)
    );

    operand_buffers #(
        .DIM (DIM)
    ) i_buffers (
        .CLOCK_50      (CLOCK_50),
        .rst_n         (rst_n),
        .readdatavalid (readdatavalid),
        .readdata      (readdata),
        .col           (col),
        .row           (row),
        .bufs          (u_buf.buffers)
    );

    // Fed straight from the queue head and B
    mac_unit i_mac (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .en       (mac_en),
        .clr      (mac_clr),
        .a        (u_buf.a_out),
        .b        (u_buf.b_out),
        .acc      (acc)
    );

    result_display i_display (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .capture  (capture),
        .acc      (acc),
        .row      (row),
        .done     (done),
        .show     (show),
        .sel      (sel),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .hex4     (hex4),
        .hex5     (hex5)
    );

endmodule

// File: verification/tb_tasks.svh
task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "Run stopped at the first error");
endtask

task automatic compare_seg(string name, seg_t got, seg_t exp);
    if (got !== exp) begin
        err_count++;
        $display("ERROR: %s = %h, expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic compare_bit(string name, logic got, logic exp);
    if (got !== exp) begin
        err_count++;
        $display("ERROR: %s = %h, expected %h", name, got, exp);
        abort_run();
    end
endtask

// Element k of a memory row, element 0 in the top byte
function automatic byte_t elem(row_t r, int k);
    return r[ROW_W - 1 - BYTE_W * k -: BYTE_W];
endfunction

// Dot product of A row r with B
function automatic acc_t expected_result(int r);
    int sum;
    sum = 0;
    for (int k = 0; k < DIM; k++)
        sum += int'(elem(mem_rows[r + 1], k)) * int'(elem(mem_rows[0], k));
    return acc_t'(sum);
endfunction

task automatic apply_reset();
    @(posedge CLOCK_50);
    rst_n <= 1'b0;
    repeat (3) @(posedge CLOCK_50);
    rst_n <= 1'b1;
endtask

task automatic wait_done();
    int cycles;
    cycles = 0;
    @(negedge CLOCK_50);
    while (done !== 1'b1) begin
        if (cycles == TEST_CYCLES) begin
            $display("Timeout while waiting for done");
            abort_run();
        end
        cycles++;
        @(negedge CLOCK_50);
    end
endtask

task automatic run_matrix();
    apply_reset();
    wait_done();
    compare_bit("read", read, 1'b0);  // No request once finished
endtask

// Select one result and compare all six digits
task automatic check_display(idx_t s, logic on, acc_t value, logic lit);
    seg_t got [6];
    seg_t exp;
    @(posedge CLOCK_50);
    sel  <= s;
    show <= on;
    @(negedge CLOCK_50);
    got = '{hex0, hex1, hex2, hex3, hex4, hex5};
    for (int i = 0; i < 6; i++) begin
        exp = lit ? SEG_HEX[value[4*i +: 4]] : SEG_OFF;
        compare_seg($sformatf("hex%0d", i), got[i], exp);
    end
endtask

task automatic check_results(logic on);
    for (int s = 0; s < DIM; s++)
        check_display(idx_t'(s), on, expected_result(s), on);
    compare_bit("done", done, 1'b1);  // Held until reset
endtask

// A with byte d on the diagonal and zero elsewhere
task automatic load_diagonal(byte_t d);
    for (int r = 0; r < DIM; r++)
        mem_rows[r + 1] = row_t'(d) << (BYTE_W * (DIM - 1 - r));
endtask

task automatic reset_test();
    apply_reset();
    @(negedge CLOCK_50);
    compare_bit("done", done, 1'b0);
    compare_bit("read", read, 1'b0);
    for (int s = 0; s < DIM; s++)
        check_display(idx_t'(s), 1'b1, '0, 1'b0);
endtask

task automatic identity_test();
    mem_rows[0] = 64'h0123_4567_89AB_CDEF;
    load_diagonal(8'h01);  // Each result equals one element of B
    run_matrix();
    check_results(1'b1);
endtask

task automatic random_test();
    for (int r = 0; r <= DIM; r++)
        mem_rows[r] = {$urandom, $urandom};
    run_matrix();
    check_results(1'b1);
endtask

// 255 times each element gives every hex digit somewhere
task automatic gating_test();
    mem_rows[0] = 64'h1234_5678_9ABC_DEF0;
    load_diagonal(8'hFF);
    run_matrix();
    check_results(1'b0);
    check_results(1'b1);
endtask

task automatic all_ones_test();
    for (int r = 0; r <= DIM; r++)
        mem_rows[r] = '1;
    run_matrix();
    for (int s = 0; s < DIM; s++)
        check_display(idx_t'(s), 1'b1, acc_t'(520200), 1'b1);
endtask

// File: verification/tb_mmul.sv
`timescale 1ns/1ns

module tb_mmul;
    import mmul_pkg::*;

    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 2000;  // Cycle budget per test
    localparam int CLK_PERIOD  = 100;

    logic              CLOCK_50      = 1'b0;
    logic              rst_n         = 1'b0;
    logic [ADDR_W-1:0] address;
    logic              read;
    row_t              readdata      = '0;
    logic              readdatavalid = 1'b0;
    logic              waitrequest   = 1'b0;
    logic              show          = 1'b0;
    idx_t              sel           = '0;
    logic              done;
    seg_t              hex0;
    seg_t              hex1;
    seg_t              hex2;
    seg_t              hex3;
    seg_t              hex4;
    seg_t              hex5;

    row_t        mem_rows [DIM+1];  // Row 0 is B, rows 1 to 8 are A
    int          err_count = 0;
    int unsigned wait_left;         // Wait states still owed to the next request
    int unsigned lat_left;
    logic [1:0]  mem_phase;         // 0 idle, 1 latency, 2 data pulse
    logic [3:0]  req_addr;

    always #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;

    mmul_top #(
        .DIM (DIM)
    ) i_mmul_top (.*);

    `include "tb_tasks.svh"

    // Memory model with random wait states and read latency
    always @(posedge CLOCK_50) begin : memory_model
        int unsigned draw;
        if (!rst_n) begin
            mem_phase     <= 2'd0;
            wait_left     <= 0;
            waitrequest   <= 1'b0;
            readdatavalid <= 1'b0;
        end else begin
            case (mem_phase)
                2'd0: begin
                    if (read && (wait_left != 0)) begin
                        wait_left   <= wait_left - 1;
                        waitrequest <= (wait_left > 1);  // Still not accepted
                    end else if (read) begin
                        if (address > ADDR_W'(DIM)) begin
                            $display("Read request outside the nine memory rows");
                            abort_run();
                        end
                        req_addr  <= address[3:0];
                        lat_left  <= $urandom_range(4, 1);
                        mem_phase <= 2'd1;
                    end
                end
                2'd1: begin
                    if (lat_left == 1) begin
                        readdata      <= mem_rows[req_addr];
                        readdatavalid <= 1'b1;
                        mem_phase     <= 2'd2;
                    end
                    lat_left <= lat_left - 1;
                end
                default: begin
                    draw = $urandom_range(2, 0);
                    readdatavalid <= 1'b0;  // One cycle pulse
                    wait_left     <= draw;
                    waitrequest   <= (draw != 0);
                    mem_phase     <= 2'd0;
                end
            endcase
        end
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $fatal(1, "Run ended by the watchdog");
    end

    initial begin
        void'($urandom(34));
        reset_test();
        identity_test();
        random_test();
        gating_test();
        all_ones_test();
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verification
src/mmul_pkg.sv
src/buf_if.sv
src/mmul_ctrl.sv
src/mmul_counters.sv
src/operand_buffers.sv
src/mac_unit.sv
src/result_display.sv
src/mmul_top.sv
verification/tb_mmul.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f vlog.f --top-module tb_mmul -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1
